//--- sim/ifmap_tests.txt
# L layer (1 A, 2 B, 3 C) | P repeats mask data | E line | W | F | Q cycles
# hex with byte 0 rightmost, each repeat of a packet adds 08 to every byte
# layer C, sparse masks, spill at 5 elements, last byte dropped
L 3
P 1 55 ff14ff13ff12ff11
P 1 f0 18171615eeeeeeee
P 1 81 1a00000000000019
P 1 ff 2221201f1e1d1c1b
P 1 0e 0000000025242300
E 00000000000000000000001514131211
E 00000000000000000000001a19181716
E 00000000000000000000001f1e1d1c1b
E 00000000000000000000002423222120
W
Q 12
F
# layer A, three batches with a two line halo
L 1
P 13 ff 0807060504030201
E 0000000d0c0b0a090807060504030201
E 0000001a191817161514131211100f0e
E 00000027262524232221201f1e1d1c1b
E 00000034333231302f2e2d2c2b2a2928
E 00000041403f3e3d3c3b3a3938373635
E 0000004e4d4c4b4a4948474645444342
E 0000005b5a595857565554535251504f
E 0000006867666564636261605f5e5d5c
W
P 9 ff 706f6e6d6c6b6a69
P 1 3f 0000b6b5b4b3b2b1
Q 12
E 0000005b5a595857565554535251504f
E 0000006867666564636261605f5e5d5c
E 000000757473727170 6f6e6d6c6b6a69
E 0000008281807f7e7d7c7b7a79787776
E 0000008f8e8d8c8b8a89888786858483
E 0000009c9b9a99989796959493929190
E 000000a9a8a7a6a5a4a3a2a1a09f9e9d
E 000000b6b5b4b3b2b1b0afaeadacabaa
F
W
P 9 ff 0807060504030201
P 1 3f 00004e4d4c4b4a49
E 000000a9a8a7a6a5a4a3a2a1a09f9e9d
E 000000b6b5b4b3b2b1b0afaeadacabaa
E 0000000d0c0b0a090807060504030201
E 0000001a191817161514131211100f0e
E 00000027262524232221201f1e1d1c1b
E 00000034333231302f2e2d2c2b2a2928
E 00000041403f3e3d3c3b3a3938373635
E 0000004e4d4c4b4a4948474645444342
F
W
Q 12
F
# layer B after a new start, no halo in its first batch
L 2
P 6 ff c8c7c6c5c4c3c2c1
P 1 3f 0000f6f5f4f3f2f1
E 00000000000000c9c8c7c6c5c4c3c2c1
E 00000000000000d2d1d0cfcecdcccbca
E 00000000000000dbdad9d8d7d6d5d4d3
E 00000000000000e4e3e2e1e0dfdedddc
E 00000000000000edecebeae9e8e7e6e5
E 00000000000000f6f5f4f3f2f1f0efee
W
P 5 ff 0807060504030201
P 1 1f 0000002d2c2b2a29
Q 12
E 00000000000000f6f5f4f3f2f1f0efee
E 00000000000000090807060504030201
E 000000000000001211100f0e0d0c0b0a
E 000000000000001b1a19181716151413
E 0000000000000024232221201f1e1d1c
E 000000000000002d2c2b2a2928272625
F
W
Q 12
F

//--- ifmap_buffer.f
+incdir+hdl
hdl/ifmap_pkg.sv
hdl/packet_compactor.sv
hdl/line_bank.sv
hdl/bank_scheduler.sv
hdl/ifmap_buffer.sv
sim/tb_ifmap_buffer.sv

//--- sim/tb_ifmap_buffer.sv
`timescale 1ns/1ns

`include "ifmap_macros.svh"

module tb_ifmap_buffer import ifmap_pkg::*; ();

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 8;
    localparam int CYCLES_PER_CMD = 200;
    localparam     TEST_FILE      = "sim/ifmap_tests.txt";

    logic          clk;
    logic          rst_n;
    logic          start;
    layer_type_e   layer_type;
    ifmap_packet_t pkt;
    logic          free;
    logic          pkt_req;
    batch_data_t   batch_data;
    logic          batch_valid;
    logic          batch_change;

    int            errors;
    int            checks;
    logic [31:0]   rng_state;
    logic [127:0]  exp_lines[$];

    ifmap_buffer i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .layer_type   (layer_type),
        .pkt          (pkt),
        .free         (free),
        .pkt_req      (pkt_req),
        .batch_data   (batch_data),
        .batch_valid  (batch_valid),
        .batch_change (batch_change)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // outputs are sampled and inputs driven 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp_val);
        checks++;
        if (got !== exp_val) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp_val);
        end
    endtask

    // next command letter, or -1 at end of file
    task automatic next_command(input int fd, output int cmd);
        int c;
        cmd = 0;
        while (cmd == 0) begin
            c = $fgetc(fd);
            if (c == -1) begin
                cmd = -1;
            end else if (c == "#") begin
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
                cmd = c;
            end
        end
    endtask

    // hex digits up to the end of the line, blanks may split digit groups
    task automatic read_hex_line(input int fd, output logic [127:0] val, output int ok);
        int   c;
        int   d;
        int   digits;
        logic bad;
        val    = '0;
        digits = 0;
        bad    = 1'b0;
        c      = $fgetc(fd);
        while (c != "\n" && c != -1) begin
            d = -1;
            if (c >= "0" && c <= "9") begin
                d = c - "0";
            end else if (c >= "a" && c <= "f") begin
                d = c - "a" + 10;
            end else if (c >= "A" && c <= "F") begin
                d = c - "A" + 10;
            end else if (c != " " && c != "\t" && c != "\r") begin
                bad = 1'b1;
            end
            if (d >= 0) begin
                val = {val[123:0], d[3:0]};
                digits++;
            end
            c = $fgetc(fd);
        end
        ok = (!bad && digits > 0 && digits <= 32) ? 1 : 0;
    endtask

    task automatic count_commands(output int n);
        int fd;
        int c;
        n = 0;
        fd = $fopen(TEST_FILE, "r");
        if (fd != 0) begin
            c = 0;
            while (c != -1) begin
                next_command(fd, c);
                if (c != -1) begin
                    n++;
                    // arguments on the rest of the line
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic start_layer(input int code);
        start      = 1'b1;
        layer_type = layer_type_e'(code);
        next_cycle();
        start = 1'b0;
    endtask

    task automatic free_batch();
        free = 1'b1;
        next_cycle();
        free = 1'b0;
    endtask

    // a few idle cycles, then present the packet only while requested
    task automatic send_packet(input logic [7:0] mask, input logic [63:0] data);
        int idle;
        rng_state = xorshift32(rng_state);
        idle = int'(rng_state[1:0]);
        repeat (idle) next_cycle();
        while (!pkt_req) begin
            next_cycle();
        end
        pkt.valid = 1'b1;
        pkt.mask  = mask;
        pkt.data  = data;
        next_cycle();
        pkt = '0;
    endtask

    // lines not listed by E must read zero
    task automatic wait_batch();
        int           waited;
        logic [127:0] exp_line;
        waited = 0;
        while (!batch_change && waited < CYCLES_PER_CMD) begin
            next_cycle();
            waited++;
        end
        if (!batch_change) begin
            errors++;
            $display("no batch_change within %0d cycles, at %0t ns", CYCLES_PER_CMD, $time);
        end else begin
            check_value("batch_valid", batch_valid, 1'b1);
            for (int l = 0; l < `IFMAP_BANK_LINES; l++) begin
                exp_line = (l < exp_lines.size()) ? exp_lines[l] : '0;
                check_value($sformatf("batch line %0d", l), batch_data[l], exp_line);
            end
            // the pulse lasts one cycle
            next_cycle();
            check_value("batch_change after pulse", batch_change, 1'b0);
        end
        exp_lines.delete();
    endtask

    task automatic expect_no_request(input int cycles);
        repeat (cycles) begin
            check_value("pkt_req held low", pkt_req, 1'b0);
            next_cycle();
        end
    endtask

    task automatic check_args(input int got, input int want, input int cmd);
        if (got != want) begin
            errors++;
            $display("command %c in %s has missing or malformed arguments", cmd, TEST_FILE);
        end
    endtask

    initial begin : main
        int           fd;
        int           cmd;
        int           n;
        int           arg;
        int           reps;
        logic [7:0]   mask;
        logic [63:0]  data;
        logic [127:0] line_val;
        errors     = 0;
        checks     = 0;
        rng_state  = 32'hfdb5;
        rst_n      = 1'b0;
        start      = 1'b0;
        layer_type = LAYER_NONE;
        pkt        = '0;
        free       = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // idle outputs until the first start
        repeat (4) begin
            next_cycle();
            check_value("pkt_req before start", pkt_req, 1'b0);
            check_value("batch_valid before start", batch_valid, 1'b0);
            check_value("batch_change before start", batch_change, 1'b0);
        end
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open %s", TEST_FILE);
        end else begin
            next_command(fd, cmd);
            while (cmd != -1) begin
                case (cmd)
                    "L": begin
                        n = $fscanf(fd, "%h", arg);
                        check_args(n, 1, cmd);
                        start_layer(arg);
                    end
                    "P": begin
                        n = $fscanf(fd, "%d %h %h", reps, mask, data);
                        check_args(n, 3, cmd);
                        // each repeat raises every byte by 8
                        for (int r = 0; r < reps; r++) begin
                            send_packet(mask, data);
                            for (int b = 0; b < 8; b++) begin
                                data[b*8 +: 8] = data[b*8 +: 8] + 8'h08;
                            end
                        end
                    end
                    "E": begin
                        read_hex_line(fd, line_val, n);
                        check_args(n, 1, cmd);
                        exp_lines.push_back(line_val);
                    end
                    "W": wait_batch();
                    "F": free_batch();
                    "Q": begin
                        n = $fscanf(fd, "%d", arg);
                        check_args(n, 1, cmd);
                        expect_no_request(arg);
                    end
                    default: begin
                        errors++;
                        $display("unknown command %c in %s", cmd, TEST_FILE);
                    end
                endcase
                next_command(fd, cmd);
            end
            $fclose(fd);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int n_cmds;
        count_commands(n_cmds);
        repeat (RESET_CYCLES + 4 + CYCLES_PER_CMD * (n_cmds + 1)) @(posedge clk);
        $display("timeout, the test commands did not complete in time");
        $display("%0d checks, %0d errors", checks, errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- hdl/ifmap_buffer.sv
`timescale 1ns/1ns

`include "ifmap_macros.svh"

module ifmap_buffer import ifmap_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  layer_type_e   layer_type,
    input  ifmap_packet_t pkt,
    input  logic          free,
    output logic          pkt_req,
    output batch_data_t   batch_data,
    output logic          batch_valid,
    output logic          batch_change
);

    layer_type_e   layer_q;
    layer_geom_t   geom;
    packed_bytes_t packed_pkt;
    batch_data_t   bank_data [2];
    logic [1:0]    bank_full;
    logic [1:0]    wr_en;
    logic [1:0]    restart;
    logic [1:0]    present_sel;
    logic          halo_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_q <= LAYER_NONE;
        end else if (start) begin
            layer_q <= layer_type;
        end
    end

    // geometry of the latched layer
    always_comb begin
        case (layer_q)
            LAYER_A: geom = '{lines:   4'(`IFMAP_A_LINES),   elems:   5'(`IFMAP_A_ELEMS),
                              overlap: 4'(`IFMAP_A_OVERLAP), batches: 4'(`IFMAP_A_BATCHES)};
            LAYER_B: geom = '{lines:   4'(`IFMAP_B_LINES),   elems:   5'(`IFMAP_B_ELEMS),
                              overlap: 4'(`IFMAP_B_OVERLAP), batches: 4'(`IFMAP_B_BATCHES)};
            LAYER_C: geom = '{lines:   4'(`IFMAP_C_LINES),   elems:   5'(`IFMAP_C_ELEMS),
                              overlap: 4'(`IFMAP_C_OVERLAP), batches: 4'(`IFMAP_C_BATCHES)};
            default: geom = '0;
        endcase
    end

    packet_compactor i_compactor (
        .pkt        (pkt),
        .packed_pkt (packed_pkt)
    );

    // ping-pong banks, each takes its halo from the other
    for (genvar b = 0; b < 2; b++) begin : g_bank
        line_bank i_bank (
            .clk        (clk),
            .rst_n      (rst_n),
            .geom       (geom),
            .packed_pkt (packed_pkt),
            .wr_en      (wr_en[b]),
            .restart    (restart[b]),
            .halo_en    (halo_en),
            .halo_src   (bank_data[1-b]),
            .data       (bank_data[b]),
            .full       (bank_full[b])
        );
    end

    bank_scheduler i_scheduler (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .geom         (geom),
        .pkt_valid    (pkt.valid),
        .full         (bank_full),
        .free         (free),
        .wr_en        (wr_en),
        .restart      (restart),
        .halo_en      (halo_en),
        .present_sel  (present_sel),
        .pkt_req      (pkt_req),
        .batch_valid  (batch_valid),
        .batch_change (batch_change)
    );

    // zero toward the PEs when no bank is presented
    always_comb begin
        case (present_sel)
            2'b01:   batch_data = bank_data[0];
            2'b10:   batch_data = bank_data[1];
            default: batch_data = '0;
        endcase
    end

endmodule

//--- hdl/bank_scheduler.sv
`timescale 1ns/1ns

module bank_scheduler import ifmap_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  layer_geom_t geom,
    input  logic        pkt_valid,
    input  logic [1:0]  full,
    input  logic        free,
    output logic [1:0]  wr_en,
    output logic [1:0]  restart,
    output logic        halo_en,
    output logic [1:0]  present_sel,
    output logic        pkt_req,
    output logic        batch_valid,
    output logic        batch_change
);

    // one-hot, zero before the first start
    logic [1:0] fill_sel;
    logic [1:0] present_q;
    logic [3:0] batch_cnt;

    logic       fill_full;
    logic       free_ok;
    logic       swap;
    logic       accept;
    logic [1:0] other_sel;

    assign fill_full = |(fill_sel & full);
    assign other_sel = {fill_sel[0], fill_sel[1]};

    // free only counts while something is presented
    assign free_ok = free && (present_sel != 2'b00);

    // a completed fill bank moves to the PE side once that side is empty
    assign swap = fill_full && ((present_sel == 2'b00) || free_ok);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_sel    <= '0;
            present_sel <= '0;
            batch_cnt   <= '0;
        end else if (start) begin
            fill_sel    <= 2'b01;
            present_sel <= '0;
            batch_cnt   <= '0;
        end else if (swap) begin
            present_sel <= fill_sel;
            fill_sel    <= other_sel;
            batch_cnt   <= batch_cnt + 4'd1;
        end else if (free_ok) begin
            present_sel <= '0;
        end
    end

    // start clears both banks, a swap reloads the new fill bank with halo
    assign restart = start ? 2'b11 : (swap ? other_sel : 2'b00);
    assign halo_en = !start;

    // stall while the fill bank waits for the PE side, stop when the layer is done
    assign pkt_req = |(fill_sel & ~full) && (batch_cnt < geom.batches);
    assign accept  = pkt_req && pkt_valid;
    assign wr_en   = fill_sel & {2{accept}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            present_q <= '0;
        end else begin
            present_q <= present_sel;
        end
    end

    assign batch_valid  = |present_sel;
    assign batch_change = batch_valid && (present_sel != present_q);

endmodule

//--- hdl/line_bank.sv
`timescale 1ns/1ns

`include "ifmap_macros.svh"

module line_bank import ifmap_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  layer_geom_t   geom,
    input  packed_bytes_t packed_pkt,
    input  logic          wr_en,
    input  logic          restart,
    input  logic          halo_en,
    input  batch_data_t   halo_src,
    output batch_data_t   data,
    output logic          full
);

    batch_data_t mem;

    // write position for the next byte
    logic [3:0] line_ptr;
    logic [4:0] elem_ptr;

    // per byte target position and pointers after the packet
    logic [3:0] byte_line [`IFMAP_PKT_BYTES];
    logic [4:0] byte_elem [`IFMAP_PKT_BYTES];
    logic [3:0] line_next;
    logic [4:0] elem_next;
    logic [3:0] walk_line;
    logic [4:0] walk_elem;

    // walk the pointers byte by byte, a short line can wrap more than once
    always_comb begin
        walk_line = line_ptr;
        walk_elem = elem_ptr;
        for (int i = 0; i < `IFMAP_PKT_BYTES; i++) begin
            byte_line[i] = walk_line;
            byte_elem[i] = walk_elem;
            if (i < packed_pkt.count && walk_line < geom.lines) begin
                if (walk_elem + 5'd1 == geom.elems) begin
                    walk_elem = '0;
                    walk_line = walk_line + 4'd1;
                end else begin
                    walk_elem = walk_elem + 5'd1;
                end
            end
        end
        line_next = walk_line;
        elem_next = walk_elem;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_ptr <= '0;
            elem_ptr <= '0;
        end else if (restart) begin
            elem_ptr <= '0;
            // halo lines are already in place, filling resumes after them
            line_ptr <= halo_en ? geom.overlap : 4'd0;
        end else if (wr_en) begin
            line_ptr <= line_next;
            elem_ptr <= elem_next;
        end
    end

    always_ff @(posedge clk) begin
        if (restart) begin
            mem <= '0;
            if (halo_en) begin
                // tail lines of the other bank become our first lines
                for (int k = 0; k < `IFMAP_BANK_LINES; k++) begin
                    if (k < geom.overlap) begin
                        mem[k] <= halo_src[geom.lines - geom.overlap + k];
                    end
                end
            end
        end else if (wr_en) begin
            for (int i = 0; i < `IFMAP_PKT_BYTES; i++) begin
                // bytes past the last line are dropped
                if (i < packed_pkt.count && byte_line[i] < geom.lines) begin
                    mem[byte_line[i]][byte_elem[i]] <= packed_pkt.bytes[i];
                end
            end
        end
    end

    assign data = mem;

    // no layer loaded means zero lines, which must not look full
    assign full = (geom.lines != 4'd0) && (line_ptr == geom.lines) && (elem_ptr == 5'd0);

endmodule

//--- hdl/packet_compactor.sv
`timescale 1ns/1ns

module packet_compactor import ifmap_pkg::*; (
    input  ifmap_packet_t pkt,
    output packed_bytes_t packed_pkt
);

    localparam int N_BYTES = $bits(pkt.mask);

    // next free slot at the low end while scanning the mask
    logic [3:0] pos;

    always_comb begin
        pos = '0;
        packed_pkt.bytes = '0;
        if (pkt.valid) begin
            for (int i = 0; i < N_BYTES; i++) begin
                // masked out bytes are skipped so packing stays dense
                if (pkt.mask[i]) begin
                    packed_pkt.bytes[pos[2:0]] = pkt.data[i];
                    pos = pos + 4'd1;
                end
            end
        end
        // an invalid packet leaves count at zero
        packed_pkt.count = pos;
    end

endmodule

//--- hdl/ifmap_pkg.sv
`include "ifmap_macros.svh"

package ifmap_pkg;

    // layer selected by the controller at start
    typedef enum logic [1:0] {
        LAYER_NONE,
        LAYER_A,
        LAYER_B,
        LAYER_C
    } layer_type_e;

    // packet as delivered by the decompressor
    typedef struct packed {
        logic                                 valid;
        logic [`IFMAP_PKT_BYTES-1:0]          mask;
        logic [`IFMAP_PKT_BYTES-1:0][7:0]     data;
    } ifmap_packet_t;

    // shape of the active layer, all zero when no layer is loaded
    typedef struct packed {
        logic [3:0] lines;
        logic [4:0] elems;
        logic [3:0] overlap;
        logic [3:0] batches;
    } layer_geom_t;

    // valid bytes moved to the low end, count runs 0 to 8
    typedef struct packed {
        logic [3:0]                           count;
        logic [`IFMAP_PKT_BYTES-1:0][7:0]     bytes;
    } packed_bytes_t;

    // contents of a whole bank, line major
    typedef logic [`IFMAP_BANK_LINES-1:0][`IFMAP_LINE_BYTES-1:0][7:0] batch_data_t;

endpackage

//--- hdl/ifmap_macros.svh
`ifndef IFMAP_MACROS_SVH
`define IFMAP_MACROS_SVH

// bytes carried by one upstream packet
`define IFMAP_PKT_BYTES 8

// storage shape of one bank
`define IFMAP_BANK_LINES 8
`define IFMAP_LINE_BYTES 16

// layer A, the large layer with a two line halo
`define IFMAP_A_LINES   8
`define IFMAP_A_ELEMS   13
`define IFMAP_A_OVERLAP 2
`define IFMAP_A_BATCHES 3

// layer B
`define IFMAP_B_LINES   6
`define IFMAP_B_ELEMS   9
`define IFMAP_B_OVERLAP 1
`define IFMAP_B_BATCHES 2

// layer C fits in a single batch
`define IFMAP_C_LINES   4
`define IFMAP_C_ELEMS   5
`define IFMAP_C_OVERLAP 0
`define IFMAP_C_BATCHES 1

`endif
